//--- project.f
+incdir+source
source/pim_pkg.sv
source/pim_kernel_store.sv
source/pim_crossbar.sv
source/pim_shift_adder.sv
source/pim_conv5x5.sv
dv/pim_conv5x5_assert.sv
dv/pim_conv5x5_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module pim_conv5x5_tb -f project.f -o sim_pim
	./obj_dir/sim_pim +verilator+error+limit+100 | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/pim_conv5x5_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pim_macros.svh"

module pim_conv5x5_tb
	import pim_pkg::*;
();

	localparam int IDLE_CYCLES = 10;
	localparam int N_B2B = 40;
	localparam int N_GAP = 20;
	localparam int N_HAZ = 8;
	localparam int N_REQ = N_B2B + N_GAP + 2 * N_HAZ + 1;
	localparam int N_WR = (`PIM_DEPTH + 1) * `PIM_TAPS;
	// Gapped requests may idle up to two cycles each
	localparam int WATCHDOG_CYCLES = N_REQ + N_WR + 2 * N_GAP + IDLE_CYCLES + 5 + 40;

	logic                                  clk;
	logic                                  rst_n;
	logic                                  wr_en;
	logic [`PIM_ADDR_W-1:0]                wr_addr;
	logic [`PIM_TAP_W-1:0]                 wr_tap;
	pim_weight_t                           wr_data;
	logic                                  in_valid;
	logic [`PIM_TAPS-1:0][`PIM_DATA_W-1:0] pixels;
	logic [`PIM_ADDR_W-1:0]                kernel_addr;
	logic                                  out_valid;
	logic [`PIM_OUT_W-1:0]                 out_data;

	logic [31:0] seed;
	int unsigned reqs_sent;
	int unsigned outs_seen;

	pim_conv5x5 dut
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_tap      (wr_tap),
		.wr_data     (wr_data),
		.in_valid    (in_valid),
		.pixels      (pixels),
		.kernel_addr (kernel_addr),
		.out_valid   (out_valid),
		.out_data    (out_data)
	);

	bind pim_conv5x5 pim_conv5x5_assert u_assert
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_tap      (wr_tap),
		.wr_data     (wr_data),
		.in_valid    (in_valid),
		.pixels      (pixels),
		.kernel_addr (kernel_addr),
		.out_valid   (out_valid),
		.out_data    (out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [7:0] rand_byte();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[23:16];
	endfunction

	function automatic logic [`PIM_TAPS-1:0][`PIM_DATA_W-1:0] random_pixels();
		logic [`PIM_TAPS-1:0][`PIM_DATA_W-1:0] pix;
		for (int t = 0; t < `PIM_TAPS; t++)
		begin
			pix[t] = rand_byte();
		end
		return pix;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic write_weight(input logic [`PIM_ADDR_W-1:0] addr,
		input logic [`PIM_TAP_W-1:0] tap, input logic [7:0] value);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_tap = tap;
		wr_data.word = value;
		next_cycle();
		wr_en = 1'b0;
	endtask

	task automatic send_request(input logic [`PIM_ADDR_W-1:0] addr,
		input logic [`PIM_TAPS-1:0][`PIM_DATA_W-1:0] pix);
		in_valid = 1'b1;
		kernel_addr = addr;
		pixels = pix;
		reqs_sent++;
		next_cycle();
		in_valid = 1'b0;
	endtask

	// Write and compute on one edge, the compute sees the old weight
	task automatic write_with_request(input logic [`PIM_ADDR_W-1:0] addr,
		input logic [`PIM_TAP_W-1:0] tap, input logic [7:0] value,
		input logic [`PIM_TAPS-1:0][`PIM_DATA_W-1:0] pix);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_tap = tap;
		wr_data.word = value;
		in_valid = 1'b1;
		kernel_addr = addr;
		pixels = pix;
		reqs_sent++;
		next_cycle();
		wr_en = 1'b0;
		in_valid = 1'b0;
	endtask

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			outs_seen <= 0;
		else if (out_valid)
			outs_seen <= outs_seen + 1;
	end

	initial
	begin
		logic [7:0] r;
		logic [`PIM_TAPS-1:0][`PIM_DATA_W-1:0] pix;
		rst_n = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_tap = '0;
		wr_data = '0;
		in_valid = 1'b0;
		pixels = '0;
		kernel_addr = '0;
		seed = 32'hbb05;
		reqs_sent = 0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		repeat (IDLE_CYCLES) next_cycle();

		for (int k = 0; k < `PIM_DEPTH; k++)
		begin
			for (int t = 0; t < `PIM_TAPS; t++)
			begin
				write_weight(`PIM_ADDR_W'(k), `PIM_TAP_W'(t), rand_byte());
			end
		end

		// Up to three requests in flight
		for (int i = 0; i < N_B2B; i++)
		begin
			r = rand_byte();
			send_request(r[`PIM_ADDR_W-1:0], random_pixels());
		end

		for (int i = 0; i < N_GAP; i++)
		begin
			r = rand_byte();
			send_request(r[`PIM_ADDR_W-1:0], random_pixels());
			repeat (r % 8'd3) next_cycle();
		end

		// Every column clamps, 255 * 17 * 255
		for (int t = 0; t < `PIM_TAPS; t++)
		begin
			write_weight(`PIM_ADDR_W'(3), `PIM_TAP_W'(t), 8'hff);
		end
		send_request(`PIM_ADDR_W'(3), {`PIM_TAPS{8'hff}});

		for (int i = 0; i < N_HAZ; i++)
		begin
			pix = random_pixels();
			r = rand_byte();
			write_with_request('0, `PIM_TAP_W'(r % 8'd25), rand_byte(), pix);
			send_request('0, pix);
		end

		wait (outs_seen == reqs_sent);
		repeat (4) next_cycle();

		if (dut.u_assert.fail_count == 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
		begin
			$display("Checks failed");
			$fatal(1, "assertion failures in the checker");
		end
	end

	initial
	begin
		wait (dut.u_assert.fail_count != 0);
		$display("Checks failed");
		$fatal(1, "an assertion in the checker failed");
	end

	initial
	begin
		#(WATCHDOG_CYCLES * 20);
		$display("Checks failed");
		$fatal(1, "timeout, the DUT did not return all results in time");
	end

endmodule

`default_nettype wire

//--- dv/pim_conv5x5_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "pim_macros.svh"

module pim_conv5x5_assert
	import pim_pkg::*;
(
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic                                          wr_en,
	input  logic [`PIM_ADDR_W-1:0]                        wr_addr,
	input  logic [`PIM_TAP_W-1:0]                         wr_tap,
	input  pim_weight_t                                   wr_data,
	input  logic                                          in_valid,
	input  logic [`PIM_TAPS-1:0][`PIM_DATA_W-1:0]         pixels,
	input  logic [`PIM_ADDR_W-1:0]                        kernel_addr,
	input  logic                                          out_valid,
	input  logic [`PIM_OUT_W-1:0]                         out_data
);

	logic [`PIM_TAPS-1:0][`PIM_DATA_W-1:0] shadow [`PIM_DEPTH];
	logic [31:0]                           expected_now;
	logic [31:0]                           exp_pipe [3];
	int unsigned                           fail_count = 0;

	// Bit-plane dot product, ADC clamp at 255, then shift by plane and nibble
	function automatic logic [31:0] conv_model(
		input logic [`PIM_TAPS-1:0][`PIM_DATA_W-1:0] pix,
		input logic [`PIM_TAPS-1:0][`PIM_DATA_W-1:0] ker
	);
		int unsigned total;
		int unsigned col;
		total = 0;
		for (int p = 0; p < 8; p++)
		begin
			for (int h = 0; h < 2; h++)
			begin
				col = 0;
				for (int t = 0; t < `PIM_TAPS; t++)
				begin
					if (pix[t][p])
					begin
						col = col + ((h == 1) ? 32'(ker[t][7:4]) : 32'(ker[t][3:0]));
					end
				end
				if (col > 32'd255)
				begin
					col = 32'd255;
				end
				total = total + (col << (p + 4 * h));
			end
		end
		return total;
	endfunction

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int k = 0; k < `PIM_DEPTH; k++)
			begin
				shadow[k] <= '0;
			end
		end
		else if (wr_en && (wr_tap < `PIM_TAP_W'(`PIM_TAPS)))
		begin
			shadow[wr_addr][wr_tap] <= wr_data.word;
		end
	end

	// Reads the kernel before a write at the same edge lands
	assign expected_now = conv_model(pixels, shadow[kernel_addr]);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 3; i++)
			begin
				exp_pipe[i] <= '0;
			end
		end
		else
		begin
			exp_pipe[0] <= expected_now;
			exp_pipe[1] <= exp_pipe[0];
			exp_pipe[2] <= exp_pipe[1];
		end
	end

	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> ##3 out_valid)
	else
	begin
		fail_count++;
		$error("out_valid did not follow in_valid after three cycles");
	end

	a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(in_valid, 3))
	else
	begin
		fail_count++;
		$error("out_valid rose with no request three cycles earlier");
	end

	a_dot_product: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (32'(out_data) == exp_pipe[2]))
	else
	begin
		fail_count++;
		$error("error dot_product expected %0d actual %0d",
			$sampled(exp_pipe[2]), $sampled(out_data));
	end

endmodule

`default_nettype wire

//--- source/pim_conv5x5.sv
`timescale 1ns/1ps
`default_nettype none

`include "pim_macros.svh"

module pim_conv5x5
	import pim_pkg::*;
(
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic                                          wr_en,
	input  logic [`PIM_ADDR_W-1:0]                        wr_addr,
	input  logic [`PIM_TAP_W-1:0]                         wr_tap,
	input  pim_weight_t                                   wr_data,
	input  logic                                          in_valid,
	input  logic [`PIM_TAPS-1:0][`PIM_DATA_W-1:0]         pixels,
	input  logic [`PIM_ADDR_W-1:0]                        kernel_addr,
	output logic                                          out_valid,
	output logic [`PIM_OUT_W-1:0]                         out_data
);

	localparam int PLANES = `PIM_DATA_W;
	localparam int COLS   = 2 * PLANES;

	pim_weight_t [`PIM_TAPS-1:0]            weights;
	logic [COLS-1:0][`PIM_ADC_BITS-1:0]     col_sums;
	logic [COLS-1:0]                        col_valid;

	pim_kernel_store u_store
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_tap      (wr_tap),
		.wr_data     (wr_data),
		.kernel_addr (kernel_addr),
		.weights     (weights)
	);

	// Column 2p holds the lo nibbles of plane p, 2p+1 the hi nibbles
	for (genvar p = 0; p < PLANES; p++)
	begin : g_plane
		logic [`PIM_TAPS-1:0] plane_bits;

		// Bit p of every pixel drives one word line
		for (genvar t = 0; t < `PIM_TAPS; t++)
		begin : g_slice
			assign plane_bits[t] = pixels[t][p];
		end

		for (genvar h = 0; h < 2; h++)
		begin : g_nib
			pim_crossbar #(
				.HI_NIBBLE (h == 1)
			) u_col
			(
				.clk        (clk),
				.rst_n      (rst_n),
				.en         (in_valid),
				.plane_bits (plane_bits),
				.weights    (weights),
				.col_sum    (col_sums[2*p+h]),
				.col_valid  (col_valid[2*p+h])
			);
		end
	end

	// All columns fire together, so column 0 speaks for them
	pim_shift_adder u_adder
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (col_valid[0]),
		.col_sums  (col_sums),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

`default_nettype wire

//--- source/pim_shift_adder.sv
`timescale 1ns/1ps
`default_nettype none

`include "pim_macros.svh"

module pim_shift_adder
(
	input  logic                                              clk,
	input  logic                                              rst_n,
	input  logic                                              in_valid,
	input  logic [2*`PIM_DATA_W-1:0][`PIM_ADC_BITS-1:0]       col_sums,
	output logic                                              out_valid,
	output logic [`PIM_OUT_W-1:0]                             out_data
);

	localparam int PLANES = `PIM_DATA_W;
	localparam int NIB_W  = `PIM_DATA_W / 2;
	// Hi sum shifted by a nibble plus lo sum, with one carry bit
	localparam int PLANE_W = `PIM_ADC_BITS + NIB_W + 1;

	logic [PLANE_W-1:0]    plane_comb [PLANES];
	logic [PLANE_W-1:0]    plane_q    [PLANES];
	logic                  s1_valid;
	logic [`PIM_OUT_W-1:0] total_comb;

	// Stage 1 merges the two nibble columns of each plane
	for (genvar p = 0; p < PLANES; p++)
	begin : g_merge
		assign plane_comb[p] = (PLANE_W'(col_sums[2*p+1]) << NIB_W)
			+ PLANE_W'(col_sums[2*p]);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			for (int p = 0; p < PLANES; p++)
			begin
				plane_q[p] <= '0;
			end
		end
		else
		begin
			s1_valid <= in_valid;
			if (in_valid)
			begin
				for (int p = 0; p < PLANES; p++)
				begin
					plane_q[p] <= plane_comb[p];
				end
			end
		end
	end

	// Stage 2 weights each plane by its bit position
	always_comb
	begin
		total_comb = '0;
		for (int p = 0; p < PLANES; p++)
		begin
			total_comb = total_comb + (`PIM_OUT_W'(plane_q[p]) << p);
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			out_data  <= '0;
		end
		else
		begin
			out_valid <= s1_valid;
			if (s1_valid)
			begin
				out_data <= total_comb;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/pim_crossbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "pim_macros.svh"

module pim_crossbar
	import pim_pkg::*;
#(
	parameter bit HI_NIBBLE = 1'b0
)
(
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             en,
	input  logic [`PIM_TAPS-1:0]             plane_bits,
	input  pim_weight_t [`PIM_TAPS-1:0]      weights,
	output logic [`PIM_ADC_BITS-1:0]         col_sum,
	output logic                             col_valid
);

	localparam int NIB_W   = `PIM_DATA_W / 2;
	localparam int NIB_MAX = (1 << NIB_W) - 1;
	// Widest possible column current, 25 taps of 15
	localparam int SUM_W   = $clog2(`PIM_TAPS * NIB_MAX + 1);
	localparam int ADC_W   = `PIM_ADC_BITS;
	localparam int ADC_MAX = (1 << ADC_W) - 1;

	logic [NIB_W-1:0] tap_nib [`PIM_TAPS];
	logic [SUM_W-1:0] dot_sum;
	logic [ADC_W-1:0] adc_code;

	// Cell conductance of each row
	for (genvar t = 0; t < `PIM_TAPS; t++)
	begin : g_cell
		if (HI_NIBBLE)
		begin : g_hi
			assign tap_nib[t] = weights[t].nib.hi;
		end
		else
		begin : g_lo
			assign tap_nib[t] = weights[t].nib.lo;
		end
	end

	// Rows driven by a set plane bit add their nibble to the column
	always_comb
	begin
		dot_sum = '0;
		for (int t = 0; t < `PIM_TAPS; t++)
		begin
			if (plane_bits[t])
			begin
				dot_sum = dot_sum + SUM_W'(tap_nib[t]);
			end
		end
	end

	// ADC clips at full scale
	assign adc_code = (dot_sum > SUM_W'(ADC_MAX)) ? ADC_W'(ADC_MAX) : ADC_W'(dot_sum);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			col_sum   <= '0;
			col_valid <= 1'b0;
		end
		else
		begin
			col_valid <= en;
			if (en)
			begin
				col_sum <= adc_code;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/pim_kernel_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "pim_macros.svh"

module pim_kernel_store
	import pim_pkg::*;
(
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             wr_en,
	input  logic [`PIM_ADDR_W-1:0]           wr_addr,
	input  logic [`PIM_TAP_W-1:0]            wr_tap,
	input  pim_weight_t                      wr_data,
	input  logic [`PIM_ADDR_W-1:0]           kernel_addr,
	output pim_weight_t [`PIM_TAPS-1:0]      weights
);

	// One row per kernel, 25 taps wide
	pim_weight_t [`PIM_TAPS-1:0] mem [`PIM_DEPTH];

	logic tap_in_range;

	// Taps 25 to 31 of the index space do not exist
	assign tap_in_range = (wr_tap < `PIM_TAP_W'(`PIM_TAPS));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int k = 0; k < `PIM_DEPTH; k++)
			begin
				mem[k] <= '0;
			end
		end
		else if (wr_en && tap_in_range)
		begin
			mem[wr_addr][wr_tap].word <= wr_data.word;
		end
	end

	// Row select of the crossbar, no read register.
	// A write at the same edge is seen only from the next cycle on.
	assign weights = mem[kernel_addr];

endmodule

`default_nettype wire

//--- source/pim_pkg.sv
`default_nettype none

`include "pim_macros.svh"

package pim_pkg;

	// Two nibble halves of one weight byte
	typedef struct packed {
		logic [`PIM_DATA_W/2-1:0] hi;
		logic [`PIM_DATA_W/2-1:0] lo;
	} pim_nibbles_t;

	// One stored weight, seen either as a byte or as two nibbles.
	// The store and write port use the byte view, the columns the nibbles.
	typedef union packed {
		logic [`PIM_DATA_W-1:0] word;
		pim_nibbles_t nib;
	} pim_weight_t;

endpackage

`default_nettype wire

//--- source/pim_macros.svh
`ifndef PIM_MACROS_SVH
`define PIM_MACROS_SVH

// Kernel window, 5x5 taps
`define PIM_TAPS 25

// Pixel and weight width
`define PIM_DATA_W 8

// Kernel memory geometry
`define PIM_DEPTH 4
`define PIM_ADDR_W 2
`define PIM_TAP_W 5

// ADC precision of one crossbar column
`define PIM_ADC_BITS 8

// Final shift-and-add result
`define PIM_OUT_W 21

`endif
